// ==== hw/daq_pkg.sv ====
package daq_pkg;

    //////////////////////////////
    // host command words
    //////////////////////////////
    typedef struct packed {
        logic [3:0]  opcode;   // upper nibble
        logic [11:0] payload;  // meaning depends on opcode
    } cmd_word_t;

    localparam logic [3:0] OP_SET_ASIC_NUM = 4'd1;  // payload[2:0]
    localparam logic [3:0] OP_SET_HEADER   = 4'd2;  // payload[7:0]
    localparam logic [3:0] OP_SET_DAC0     = 4'd3;  // payload[9:0]
    localparam logic [3:0] OP_SET_DAC1     = 4'd4;
    localparam logic [3:0] OP_SET_DAC2     = 4'd5;
    localparam logic [3:0] OP_SET_ACQ_TIME = 4'd6;  // in clk cycles
    localparam logic [3:0] OP_LOAD_SC      = 4'd8;
    localparam logic [3:0] OP_ACQ_START    = 4'd9;

    // readout side
    typedef logic [15:0] data_word_t;

    //////////////////////////////
    // slow control frame
    //////////////////////////////
    typedef logic [9:0] dac_t;  // threshold dac code

    // shifted msb first, header leads
    typedef struct packed {
        logic [7:0] header;
        dac_t       dac2;
        dac_t       dac1;
        dac_t       dac0;
    } sc_frame_t;

    localparam int SC_FRAME_BITS = 38;
    localparam int MAX_ASICS     = 4;   // length of the daisy chain
    localparam int ACQ_TIME_W    = 12;

    // acquisition window after reset
    localparam logic [ACQ_TIME_W-1:0] ACQ_TIME_RST = 12'd8;

endpackage

// ==== hw/sync_fifo.sv ====
`timescale 1ns/1ns

module sync_fifo #(
    parameter type payload_t = logic [15:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wr_en,
    input  payload_t din,
    input  logic     rd_en,
    output payload_t dout,
    output logic     full,
    output logic     empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;   // occupancy, never above DEPTH

    // circular increment, depth need not be a power of two
    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full  = (count == CW'(DEPTH));
    assign empty = (count == '0);
    assign dout  = mem[rd_ptr];  // head word shown ahead of the pop

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= ptr_inc(wr_ptr);
            if (rd_en) rd_ptr <= ptr_inc(rd_ptr);
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // both or neither, level unchanged
            endcase
        end
    end

    // producer and consumer must honour the flags
    a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> !full);
    a_no_read_empty: assert property (@(posedge clk) disable iff (!rst_n) rd_en |-> !empty);

endmodule

// ==== hw/usb_cmd_decoder.sv ====
`timescale 1ns/1ns

module usb_cmd_decoder import daq_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cmd_word_t             cmd_word,
    input  logic                  cmd_empty,
    input  logic                  sc_busy,
    input  logic                  acq_busy,
    output logic                  cmd_rd_en,
    output logic                  sc_start,
    output sc_frame_t             sc_frame,
    output logic [2:0]            asic_num,
    output logic                  acq_start,
    output logic [ACQ_TIME_W-1:0] acq_time
);

    cmd_word_t  cmd_q;     // word popped on the last edge
    logic       cmd_vld;
    logic       launch_q;  // load or acq command sitting in cmd_q
    logic [2:0] num_req;
    logic [7:0] header;
    dac_t       dac0;
    dac_t       dac1;
    dac_t       dac2;

    assign launch_q = cmd_vld &&
                      (cmd_q.opcode == OP_LOAD_SC || cmd_q.opcode == OP_ACQ_START);

    // no pop while a launch is queued, in flight or still running
    // busy from the blocks only rises one cycle after the start pulse
    assign cmd_rd_en = !cmd_empty && !sc_busy && !acq_busy &&
                       !launch_q && !sc_start && !acq_start;

    assign num_req  = cmd_q.payload[2:0];
    assign sc_frame = '{header: header, dac2: dac2, dac1: dac1, dac0: dac0};

    //////////////////////////////
    // command capture
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (cmd_rd_en) begin
            cmd_q <= cmd_word;  // fifo head at the pop
        end
    end

    //////////////////////////////
    // decode and config regs
    //////////////////////////////
    // push edge, pop edge, then the register or start pulse updates
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmd_vld   <= 1'b0;
            sc_start  <= 1'b0;
            acq_start <= 1'b0;
            asic_num  <= 3'd1;
            header    <= '0;
            dac0      <= '0;
            dac1      <= '0;
            dac2      <= '0;
            acq_time  <= ACQ_TIME_RST;
        end else begin
            cmd_vld   <= cmd_rd_en;
            sc_start  <= 1'b0;  // single cycle pulses
            acq_start <= 1'b0;
            if (cmd_vld) begin
                case (cmd_q.opcode)
                    OP_SET_ASIC_NUM: begin
                        // out of range counts fall back to a single asic
                        if (num_req == 3'd0 || num_req > 3'(MAX_ASICS)) begin
                            asic_num <= 3'd1;
                        end else begin
                            asic_num <= num_req;
                        end
                    end
                    OP_SET_HEADER:   header   <= cmd_q.payload[7:0];
                    OP_SET_DAC0:     dac0     <= cmd_q.payload[9:0];
                    OP_SET_DAC1:     dac1     <= cmd_q.payload[9:0];
                    OP_SET_DAC2:     dac2     <= cmd_q.payload[9:0];
                    OP_SET_ACQ_TIME: acq_time <= cmd_q.payload[ACQ_TIME_W-1:0];
                    OP_LOAD_SC:      sc_start  <= 1'b1;
                    OP_ACQ_START:    acq_start <= 1'b1;
                    default: ;  // unknown opcode, dropped
                endcase
            end
        end
    end

endmodule

// ==== hw/sc_shifter.sv ====
`timescale 1ns/1ns

module sc_shifter import daq_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  sc_frame_t  frame,
    input  logic [2:0] asic_num,
    output logic       busy,
    output logic       sc_select,
    output logic       sr_rstb,
    output logic       sr_ck,
    output logic       sr_in,
    output logic       config_done
);

    typedef enum logic [1:0] {S_IDLE, S_SHIFT, S_DONE} state_t;

    localparam int BW = $clog2(SC_FRAME_BITS);

    state_t                   state;
    logic [SC_FRAME_BITS-1:0] shreg;      // frame being shifted out
    logic [BW-1:0]            bit_cnt;    // bit within current asic frame
    logic [2:0]               asic_cnt;
    logic [2:0]               asic_last;  // asic_num - 1, held for the load
    logic                     frame_end;
    logic                     chain_end;

    assign frame_end = (bit_cnt == BW'(SC_FRAME_BITS - 1));
    assign chain_end = frame_end && (asic_cnt == asic_last);
    assign sr_in     = shreg[SC_FRAME_BITS-1];  // msb first
    assign busy      = (state != S_IDLE);

    //////////////////////////////
    // sequencing
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= S_IDLE;
            sc_select   <= 1'b0;
            sr_rstb     <= 1'b0;  // asic registers held in reset until first load
            sr_ck       <= 1'b0;
            config_done <= 1'b0;
            bit_cnt     <= '0;
            asic_cnt    <= '0;
        end else begin
            config_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state     <= S_SHIFT;
                        sc_select <= 1'b1;
                        sr_rstb   <= 1'b1;  // stays released afterwards
                        sr_ck     <= 1'b0;
                        bit_cnt   <= '0;
                        asic_cnt  <= '0;
                    end
                end
                S_SHIFT: begin
                    sr_ck <= ~sr_ck;  // sr_ck doubles as the phase toggle
                    if (sr_ck) begin  // falling edge, move to the next bit
                        if (chain_end) begin
                            state <= S_DONE;
                        end else if (frame_end) begin
                            bit_cnt  <= '0;
                            asic_cnt <= asic_cnt + 3'd1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                S_DONE: begin
                    state       <= S_IDLE;  // busy drops with the done pulse
                    sc_select   <= 1'b0;
                    config_done <= 1'b1;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // frame data
    always_ff @(posedge clk) begin
        if (state == S_IDLE && start) begin
            shreg     <= frame;
            asic_last <= asic_num - 3'd1;
        end else if (state == S_SHIFT && sr_ck) begin
            if (frame_end) begin
                shreg <= frame;  // same frame again for the next asic
            end else begin
                shreg <= shreg << 1;
            end
        end
    end

    // asic samples sr_in on the rising sr_ck
    a_sr_in_stable: assert property (@(posedge clk) disable iff (!rst_n)
        sr_ck |-> $stable(sr_in));

endmodule

// ==== hw/acq_sequencer.sv ====
`timescale 1ns/1ns

module acq_sequencer import daq_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic [ACQ_TIME_W-1:0] acq_time,
    input  logic                  chipsatb,     // low when asic memory is full
    input  logic                  end_readout,
    output logic                  busy,
    output logic                  start_acq,
    output logic                  start_readout
);

    typedef enum logic [1:0] {S_IDLE, S_ACQ, S_RDO, S_WAIT} state_t;

    state_t                state;
    logic [ACQ_TIME_W-1:0] remain;    // acquisition cycles left
    logic                  acq_stop;

    // last timed cycle or chip full
    assign acq_stop = (remain <= ACQ_TIME_W'(1)) || !chipsatb;
    assign busy     = (state != S_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= S_IDLE;
            remain        <= '0;
            start_acq     <= 1'b0;
            start_readout <= 1'b0;
        end else begin
            start_readout <= 1'b0;  // one cycle pulse
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state     <= S_ACQ;
                        start_acq <= 1'b1;
                        remain    <= acq_time;
                    end
                end
                S_ACQ: begin
                    remain <= remain - 1'b1;
                    if (acq_stop) begin
                        state         <= S_RDO;
                        start_acq     <= 1'b0;
                        start_readout <= 1'b1;  // right behind start_acq
                    end
                end
                S_RDO: begin
                    state <= S_WAIT;
                end
                S_WAIT: begin
                    if (end_readout) begin
                        state <= S_IDLE;  // readout length set by the chip
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // acquisition and readout never overlap on the asic
    a_acq_rdo_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(start_acq && start_readout));

endmodule

// ==== hw/readout_packer.sv ====
`timescale 1ns/1ns

module readout_packer import daq_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       doutb,        // serial data, active low
    input  logic       transmitonb,  // low while a bit is on doutb
    input  logic       fifo_full,
    output logic       push,
    output data_word_t word,
    output logic       overflow
);

    data_word_t shreg;     // deserializer, newest bit at lsb
    logic [3:0] bit_cnt;
    logic       word_vld;  // shreg holds 16 fresh bits this cycle

    // asic can't be stalled, a word meeting a full fifo is lost
    assign push = word_vld && !fifo_full;
    assign word = shreg;   // written on the edge before the next shift lands

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bit_cnt  <= '0;
            word_vld <= 1'b0;
            overflow <= 1'b0;
        end else begin
            word_vld <= !transmitonb && (bit_cnt == 4'd15);
            if (!transmitonb) begin
                bit_cnt <= bit_cnt + 4'd1;  // wraps every 16 bits
            end
            if (word_vld && fifo_full) begin
                overflow <= 1'b1;  // sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!transmitonb) begin
            shreg <= {shreg[14:0], ~doutb};  // first bit ends up as msb
        end
    end

endmodule

// ==== hw/daq_top.sv ====
`timescale 1ns/1ns

module daq_top import daq_pkg::*; #(
    parameter int CMD_DEPTH  = 4,
    parameter int DATA_DEPTH = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    input  cmd_word_t  cmd_data,
    input  logic       cmd_valid,
    output logic       cmd_ready,
    output data_word_t data_out,
    output logic       data_valid,
    input  logic       data_ready,
    output logic       sc_select,
    output logic       sr_rstb,
    output logic       sr_ck,
    output logic       sr_in,
    output logic       config_done,
    output logic       start_acq,
    input  logic       chipsatb,
    output logic       start_readout,
    input  logic       end_readout,
    output logic       acq_busy,
    input  logic       doutb,
    input  logic       transmitonb,
    output logic       overflow
);

    cmd_word_t             cmd_word;    // head of command fifo
    logic                  cmd_full;
    logic                  cmd_empty;
    logic                  cmd_rd_en;
    logic                  sc_start;
    sc_frame_t             sc_frame;
    logic [2:0]            asic_num;
    logic                  sc_busy;
    logic                  acq_start;
    logic [ACQ_TIME_W-1:0] acq_time;
    logic                  pk_push;
    data_word_t            pk_word;
    logic                  data_full;
    logic                  data_empty;

    assign cmd_ready  = ~cmd_full;
    assign data_valid = ~data_empty;

    //////////////////////////////
    // host command path
    //////////////////////////////
    sync_fifo #(.payload_t(cmd_word_t), .DEPTH(CMD_DEPTH)) i_cmd_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wr_en (cmd_valid && cmd_ready),
        .din   (cmd_data),
        .rd_en (cmd_rd_en),
        .dout  (cmd_word),
        .full  (cmd_full),
        .empty (cmd_empty)
    );

    usb_cmd_decoder i_usb_cmd_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_word  (cmd_word),
        .cmd_empty (cmd_empty),
        .sc_busy   (sc_busy),
        .acq_busy  (acq_busy),
        .cmd_rd_en (cmd_rd_en),
        .sc_start  (sc_start),
        .sc_frame  (sc_frame),
        .asic_num  (asic_num),
        .acq_start (acq_start),
        .acq_time  (acq_time)
    );

    //////////////////////////////
    // asic control
    //////////////////////////////
    sc_shifter i_sc_shifter (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (sc_start),
        .frame       (sc_frame),
        .asic_num    (asic_num),
        .busy        (sc_busy),
        .sc_select   (sc_select),
        .sr_rstb     (sr_rstb),
        .sr_ck       (sr_ck),
        .sr_in       (sr_in),
        .config_done (config_done)
    );

    acq_sequencer i_acq_sequencer (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (acq_start),
        .acq_time      (acq_time),
        .chipsatb      (chipsatb),
        .end_readout   (end_readout),
        .busy          (acq_busy),
        .start_acq     (start_acq),
        .start_readout (start_readout)
    );

    //////////////////////////////
    // readout data path
    //////////////////////////////
    readout_packer i_readout_packer (
        .clk         (clk),
        .rst_n       (rst_n),
        .doutb       (doutb),
        .transmitonb (transmitonb),
        .fifo_full   (data_full),
        .push        (pk_push),
        .word        (pk_word),
        .overflow    (overflow)
    );

    sync_fifo #(.payload_t(data_word_t), .DEPTH(DATA_DEPTH)) i_data_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wr_en (pk_push),
        .din   (pk_word),
        .rd_en (data_ready && data_valid),  // host takes the word
        .dout  (data_out),
        .full  (data_full),
        .empty (data_empty)
    );

endmodule

// ==== tb/tb_tasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

//////////////////////////////
// random bits
//////////////////////////////
logic [15:0] lfsr_state;  // seeded by the main initial block

// galois lfsr x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] val;
    logic        b;
    int          i;
    val = '0;
    for (i = 0; i < n; i++) begin
        b          = lfsr_state[0];
        lfsr_state = {1'b0, lfsr_state[15:1]} ^ (b ? 16'hB400 : 16'h0000);
        val        = {val[30:0], b};  // first bit lands at the msb
    end
    return val;
endfunction

//////////////////////////////
// checking
//////////////////////////////
task automatic report_failure(input string what);
    $display("ERROR: %s", what);
    $display("SIMULATION FAILED");
    $fatal(1, "run aborted");
endtask

task automatic check_eq(input string name, input logic [63:0] expected,
                        input logic [63:0] actual);
    if (expected !== actual) begin
        $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        $display("SIMULATION FAILED");
        $fatal(1, "value mismatch");
    end
endtask

//////////////////////////////
// drive helpers
//////////////////////////////
// inputs change and outputs are read 2 ns after the edge
task automatic next_cycle();
    @(posedge clk);
    #2;
endtask

task automatic send_cmd(input logic [3:0] op, input logic [11:0] payload);
    cmd_data.opcode  = op;
    cmd_data.payload = payload;
    cmd_valid        = 1'b1;
    while (!cmd_ready) next_cycle();
    next_cycle();  // fifo takes the word on this edge
    cmd_valid = 1'b0;
endtask

// one word msb first and inverted as the asic sends it
task automatic shift_word(input data_word_t w, input bit gaps);
    int i;
    for (i = 15; i >= 0; i--) begin
        doutb       = ~w[i];
        transmitonb = 1'b0;
        next_cycle();
        if (gaps && (i % 5 == 0)) begin
            transmitonb = 1'b1;  // idle gap without a sample
            doutb       = 1'b1;
            repeat (2) next_cycle();
        end
    end
endtask

// sequencer sits in its wait state until end_readout
task automatic finish_readout(input string name);
    check_eq({name, " busy in readout"}, 64'(1), 64'(acq_busy));
    next_cycle();
    check_eq({name, " busy before end"}, 64'(1), 64'(acq_busy));
    end_readout = 1'b1;
    next_cycle();
    end_readout = 1'b0;
    check_eq({name, " busy after end"}, 64'(0), 64'(acq_busy));
endtask

// bounds the whole run
initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    report_failure("watchdog timeout, the tests did not finish in time");
end

`endif

// ==== tb/daq_top_tb.sv ====
`timescale 1ns/1ns

module daq_top_tb import daq_pkg::*; ();

    localparam int CLK_PERIOD  = 40;
    localparam int CMD_DEPTH   = 4;
    localparam int DATA_DEPTH  = 16;
    // rough length of each test in cycles
    localparam int SC_CYCLES   = 4 * SC_FRAME_BITS + 64;   // two asics at 2 cycles per bit
    localparam int ACQ_CYCLES  = 20 + 7 + 80;
    localparam int PACK_CYCLES = 48 * 3 + 16;
    localparam int BP_CYCLES   = (DATA_DEPTH + 2) * 16 + 2 * DATA_DEPTH + 16;
    localparam int WATCHDOG_CYCLES = 8 + SC_CYCLES + ACQ_CYCLES + PACK_CYCLES + BP_CYCLES + 200;

    logic       clk;
    logic       rst_n;
    cmd_word_t  cmd_data;
    logic       cmd_valid;
    logic       cmd_ready;
    data_word_t data_out;
    logic       data_valid;
    logic       data_ready;
    logic       sc_select;
    logic       sr_rstb;
    logic       sr_ck;
    logic       sr_in;
    logic       config_done;
    logic       start_acq;
    logic       chipsatb;
    logic       start_readout;
    logic       end_readout;
    logic       acq_busy;
    logic       doutb;
    logic       transmitonb;
    logic       overflow;
    data_word_t rx_q [$];  // words taken by the host side

    `include "tb_tasks.svh"

    daq_top #(.CMD_DEPTH(CMD_DEPTH), .DATA_DEPTH(DATA_DEPTH)) i_daq_top (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // word leaves on the next rising edge
    always @(negedge clk) begin
        if (rst_n && data_valid && data_ready) rx_q.push_back(data_out);
    end

    //////////////////////////////
    // directed tests
    //////////////////////////////
    task automatic test_sc_load();
        logic [7:0]  hdr;
        logic [9:0]  d0;
        logic [9:0]  d1;
        logic [9:0]  d2;
        logic [37:0] exp_frame;
        logic        prev_ck;
        int          nbits;
        int          ndone;
        hdr = 8'(lfsr_bits(8));
        d0  = 10'(lfsr_bits(10));
        d1  = 10'(lfsr_bits(10));
        d2  = 10'(lfsr_bits(10));
        exp_frame = {hdr, d2, d1, d0};  // header leads
        send_cmd(OP_SET_ASIC_NUM, 12'd2);
        send_cmd(OP_SET_HEADER, {4'd0, hdr});
        send_cmd(OP_SET_DAC0, {2'd0, d0});
        send_cmd(OP_SET_DAC1, {2'd0, d1});
        send_cmd(OP_SET_DAC2, {2'd0, d2});
        send_cmd(OP_LOAD_SC, 12'd0);
        while (!sc_select) next_cycle();
        prev_ck = 1'b0;
        nbits   = 0;
        while (!config_done) begin
            check_eq("sc_load sc_select", 64'(1), 64'(sc_select));
            if (sr_ck && !prev_ck) begin  // asic samples here
                check_eq($sformatf("sc_load bit %0d", nbits),
                         64'(exp_frame[SC_FRAME_BITS - 1 - nbits % SC_FRAME_BITS]), 64'(sr_in));
                nbits++;
            end
            prev_ck = sr_ck;
            next_cycle();
        end
        check_eq("sc_load bit count", 64'(2 * SC_FRAME_BITS), 64'(nbits));
        ndone = 0;
        repeat (4) begin
            if (config_done) ndone++;
            next_cycle();
        end
        check_eq("sc_load config_done pulses", 64'(1), 64'(ndone));
        check_eq("sc_load sr_rstb", 64'(1), 64'(sr_rstb));
    endtask

    task automatic test_acq_timer();
        int n;
        int i;
        send_cmd(OP_SET_ACQ_TIME, 12'd20);
        send_cmd(OP_ACQ_START, 12'd0);
        while (!start_acq) next_cycle();
        n = 0;
        while (start_acq) begin
            n++;
            next_cycle();
        end
        check_eq("acq_timer start_acq cycles", 64'(20), 64'(n));
        check_eq("acq_timer start_readout", 64'(1), 64'(start_readout));
        next_cycle();
        check_eq("acq_timer readout pulse width", 64'(0), 64'(start_readout));
        // decoder pops nothing while the sequencer waits for end_readout
        for (i = 0; i < CMD_DEPTH; i++) send_cmd(4'hF, 12'd0);  // unused opcode
        check_eq("acq_timer cmd_ready with fifo full", 64'(0), 64'(cmd_ready));
        finish_readout("acq_timer");
    endtask

    task automatic test_acq_full();
        int n;
        send_cmd(OP_SET_ACQ_TIME, 12'd200);
        send_cmd(OP_ACQ_START, 12'd0);
        while (!start_acq) next_cycle();
        n = 0;
        while (start_acq) begin
            n++;
            if (n == 7) chipsatb = 1'b0;  // memory full
            next_cycle();
        end
        chipsatb = 1'b1;
        check_eq("acq_full start_acq cycles", 64'(7), 64'(n));
        check_eq("acq_full start_readout", 64'(1), 64'(start_readout));
        next_cycle();
        finish_readout("acq_full");
    endtask

    task automatic test_packing();
        data_word_t exp_w [3];
        int         i;
        rx_q.delete();
        for (i = 0; i < 3; i++) begin
            exp_w[i] = 16'(lfsr_bits(16));
            shift_word(exp_w[i], 1'b1);
        end
        transmitonb = 1'b1;
        while (rx_q.size() < 3) next_cycle();
        for (i = 0; i < 3; i++) begin
            check_eq($sformatf("packing word %0d", i), 64'(exp_w[i]), 64'(rx_q[i]));
        end
        check_eq("packing overflow", 64'(0), 64'(overflow));
    endtask

    task automatic test_backpressure();
        data_word_t exp_w [DATA_DEPTH + 2];
        int         i;
        data_ready = 1'b0;
        rx_q.delete();
        for (i = 0; i < DATA_DEPTH + 2; i++) exp_w[i] = 16'(lfsr_bits(16));
        for (i = 0; i < DATA_DEPTH + 2; i++) shift_word(exp_w[i], 1'b0);
        transmitonb = 1'b1;
        repeat (3) next_cycle();
        check_eq("backpressure overflow", 64'(1), 64'(overflow));
        check_eq("backpressure data_valid", 64'(1), 64'(data_valid));
        check_eq("backpressure head word held", 64'(exp_w[0]), 64'(data_out));
        data_ready = 1'b1;
        next_cycle();
        while (data_valid) next_cycle();
        repeat (2) next_cycle();
        check_eq("backpressure word count", 64'(DATA_DEPTH), 64'(rx_q.size()));
        for (i = 0; i < DATA_DEPTH; i++) begin
            check_eq($sformatf("backpressure word %0d", i), 64'(exp_w[i]), 64'(rx_q[i]));
        end
        check_eq("backpressure overflow sticky", 64'(1), 64'(overflow));
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        lfsr_state  = 16'd42;
        rst_n       = 1'b0;
        cmd_data    = '0;
        cmd_valid   = 1'b0;
        data_ready  = 1'b1;
        chipsatb    = 1'b1;  // memory not full
        end_readout = 1'b0;
        doutb       = 1'b1;
        transmitonb = 1'b1;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_eq("reset outputs", 64'(0),
                 64'({sc_select, sr_rstb, sr_ck, start_acq, start_readout,
                      config_done, acq_busy, overflow}));
        test_sc_load();
        test_acq_timer();
        test_acq_full();
        test_packing();
        test_backpressure();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== daq_top.f ====
+incdir+tb
hw/daq_pkg.sv
hw/sync_fifo.sv
hw/usb_cmd_decoder.sv
hw/sc_shifter.sv
hw/acq_sequencer.sv
hw/readout_packer.sv
hw/daq_top.sv
tb/daq_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module daq_top_tb -f daq_top.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vdaq_top_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi
exit 0
